// File: design/gpu_cmd_pkg.sv
/*
 * Shared types and command word layout for the GPU command front end.
 * Modules reference everything here by scoped names.
 */

package gpu_cmd_pkg;

    // VRAM word address and data word
    typedef logic [31:0] vram_addr_t;
    typedef logic [15:0] pixel_t;

    // Command word fields
    localparam int OP_POS = 24;
    localparam int OP_SIZE = 8;
    localparam int HALF_SEL_BIT = 16;
    localparam int WAIT_VSYNC_BIT = 0;

    // Opcodes kept by the front end, anything else is dropped
    typedef enum logic [7:0] {
        OP_CLEAR        = 8'h20,
        OP_SWAP         = 8'h21,
        OP_SET_TEX_ADDR = 8'h22,
        OP_WRITE_TEX    = 8'h23
    } opcode_e;

    // Decode stage to buffer stage
    typedef struct packed {
        opcode_e op;
        // Upper half for tex address, depth buffer for clear
        logic    half_sel;
        logic    wait_vsync;
        pixel_t  value;
    } decoded_cmd_t;

    // Buffer stage to VRAM writer
    typedef struct packed {
        vram_addr_t  base;
        // Number of words to write
        logic [31:0] count;
        pixel_t      value;
    } write_job_t;

endpackage

// File: design/cmd_decoder.sv
/*
 * Stage 1 of the command pipeline. Accepts 32-bit command words on a
 * valid/ready input, keeps one word and hands it on as a decoded command.
 */

module cmd_decoder (
    input  wire logic                      clk,
    input  wire logic                      reset_i,

    // Command stream input
    input  wire logic                      cmd_tvalid_i,
    output      logic                      cmd_tready_o,
    input  wire logic [31:0]               cmd_tdata_i,

    // Decoded command to the buffer stage
    output      logic                      dec_valid_o,
    input  wire logic                      dec_ready_i,
    output      gpu_cmd_pkg::decoded_cmd_t dec_cmd_o
    );

    logic                      dec_valid_q;
    gpu_cmd_pkg::decoded_cmd_t dec_cmd_q;

    gpu_cmd_pkg::opcode_e      word_op;
    gpu_cmd_pkg::decoded_cmd_t word_cmd;
    logic                      op_known;
    logic                      accept;

    // Split the incoming word
    always_comb begin
        word_op = gpu_cmd_pkg::opcode_e'(cmd_tdata_i[gpu_cmd_pkg::OP_POS +: gpu_cmd_pkg::OP_SIZE]);

        case (word_op)
            gpu_cmd_pkg::OP_CLEAR,
            gpu_cmd_pkg::OP_SWAP,
            gpu_cmd_pkg::OP_SET_TEX_ADDR,
            gpu_cmd_pkg::OP_WRITE_TEX:
                op_known = 1'b1;
            default:
                op_known = 1'b0;
        endcase

        word_cmd.op         = word_op;
        word_cmd.half_sel   = cmd_tdata_i[gpu_cmd_pkg::HALF_SEL_BIT];
        word_cmd.wait_vsync = cmd_tdata_i[gpu_cmd_pkg::WAIT_VSYNC_BIT];
        word_cmd.value      = cmd_tdata_i[15:0];
    end

    // Free slot or slot drained this cycle
    assign cmd_tready_o = !dec_valid_q || dec_ready_i;
    assign accept = cmd_tvalid_i && cmd_tready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            // Unknown opcodes are swallowed here
            dec_valid_q <= op_known;
        end else if (dec_ready_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && op_known) begin
            dec_cmd_q <= word_cmd;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_cmd_o   = dec_cmd_q;

    // Held command must not change under back-pressure
    property p_dec_hold;
        @(posedge clk) disable iff (reset_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_cmd_o);
    endproperty

    assert property (p_dec_hold)
        else $error("decoded command changed while stalled");

endmodule

// File: design/buffer_manager.sv
/*
 * Stage 2 of the command pipeline. Owns the front, back and texture
 * pointers, performs buffer swaps and turns clears and texel writes
 * into write jobs for the VRAM writer.
 */

module buffer_manager #(
    parameter int FB_WIDTH = 128,
    parameter int FB_HEIGHT = 128
    ) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,

    // Decoded command from stage 1
    input  wire logic                      dec_valid_i,
    output      logic                      dec_ready_o,
    input  wire gpu_cmd_pkg::decoded_cmd_t dec_cmd_i,

    // Write job to stage 3
    output      logic                      job_valid_o,
    input  wire logic                      job_ready_i,
    output      gpu_cmd_pkg::write_job_t   job_o,

    // Display side
    input  wire logic                      vsync_i,
    output      logic                      swap_o,
    output      gpu_cmd_pkg::vram_addr_t   front_addr_o
    );

    // VRAM layout
    localparam gpu_cmd_pkg::vram_addr_t FB_WORDS = gpu_cmd_pkg::vram_addr_t'(FB_WIDTH * FB_HEIGHT);
    localparam gpu_cmd_pkg::vram_addr_t DEPTH_BASE = 2 * FB_WORDS;
    localparam gpu_cmd_pkg::vram_addr_t TEX_BASE = 3 * FB_WORDS;

    gpu_cmd_pkg::vram_addr_t front_q, back_q, tex_ptr_q;
    logic                    swap_pend_q;
    logic                    job_valid_q;
    gpu_cmd_pkg::write_job_t job_q;
    gpu_cmd_pkg::write_job_t next_job;

    logic take;
    logic needs_job;
    logic job_free;
    logic do_swap;

    assign job_free  = !job_valid_q || job_ready_i;
    assign needs_job = dec_cmd_i.op == gpu_cmd_pkg::OP_CLEAR ||
                       dec_cmd_i.op == gpu_cmd_pkg::OP_WRITE_TEX;

    // A waiting swap blocks everything behind it
    always_comb begin
        dec_ready_o = 1'b0;
        if (!swap_pend_q) begin
            case (dec_cmd_i.op)
                gpu_cmd_pkg::OP_CLEAR,
                gpu_cmd_pkg::OP_WRITE_TEX: dec_ready_o = job_free;
                // Keeps swap pulses apart
                gpu_cmd_pkg::OP_SWAP:      dec_ready_o = !swap_o;
                default:                   dec_ready_o = 1'b1;
            endcase
        end
    end

    assign take = dec_valid_i && dec_ready_o;

    assign do_swap = (swap_pend_q && vsync_i) ||
                     (take && dec_cmd_i.op == gpu_cmd_pkg::OP_SWAP &&
                      (!dec_cmd_i.wait_vsync || vsync_i));

    // Job resolved against the pointers of this cycle
    always_comb begin
        next_job.value = dec_cmd_i.value;
        if (dec_cmd_i.op == gpu_cmd_pkg::OP_WRITE_TEX) begin
            next_job.base  = tex_ptr_q;
            next_job.count = 32'd1;
        end else begin
            next_job.base  = dec_cmd_i.half_sel ? DEPTH_BASE : back_q;
            next_job.count = FB_WORDS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            front_q     <= '0;
            back_q      <= FB_WORDS;
            tex_ptr_q   <= TEX_BASE;
            swap_pend_q <= 1'b0;
            job_valid_q <= 1'b0;
            swap_o      <= 1'b0;
        end else begin
            swap_o <= do_swap;
            if (do_swap) begin
                front_q <= back_q;
                back_q  <= front_q;
            end

            if (swap_pend_q && vsync_i) begin
                swap_pend_q <= 1'b0;
            end else if (take && dec_cmd_i.op == gpu_cmd_pkg::OP_SWAP && !do_swap) begin
                swap_pend_q <= 1'b1;
            end

            if (take && needs_job) begin
                job_valid_q <= 1'b1;
            end else if (job_ready_i) begin
                job_valid_q <= 1'b0;
            end

            if (take && dec_cmd_i.op == gpu_cmd_pkg::OP_WRITE_TEX) begin
                tex_ptr_q <= tex_ptr_q + 1'b1;
            end else if (take && dec_cmd_i.op == gpu_cmd_pkg::OP_SET_TEX_ADDR) begin
                if (dec_cmd_i.half_sel) begin
                    tex_ptr_q[31:16] <= dec_cmd_i.value;
                end else begin
                    tex_ptr_q[15:0] <= dec_cmd_i.value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && needs_job) begin
            job_q <= next_job;
        end
    end

    assign job_valid_o  = job_valid_q;
    assign job_o        = job_q;
    assign front_addr_o = front_q;

    property p_swap_single;
        @(posedge clk) disable iff (reset_i)
        swap_o |=> !swap_o;
    endproperty

    assert property (p_swap_single)
        else $error("swap pulse longer than one cycle");

endmodule

// File: design/vram_writer.sv
/*
 * Stage 3 of the command pipeline. Runs each write job as a series of
 * Wishbone classic single writes at base, base+1 and onward.
 */

module vram_writer (
    input  wire logic                    clk,
    input  wire logic                    reset_i,

    // Write job from stage 2
    input  wire logic                    job_valid_i,
    output      logic                    job_ready_o,
    input  wire gpu_cmd_pkg::write_job_t job_i,

    // Wishbone classic master, writes only
    output      logic                    wb_cyc_o,
    output      logic                    wb_stb_o,
    output      logic                    wb_we_o,
    output      logic [1:0]              wb_sel_o,
    output      gpu_cmd_pkg::vram_addr_t wb_adr_o,
    output      gpu_cmd_pkg::pixel_t     wb_dat_o,
    input  wire logic                    wb_ack_i
    );

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        GAP
    } wr_state_e;

    wr_state_e               state;
    gpu_cmd_pkg::vram_addr_t adr_q;
    gpu_cmd_pkg::pixel_t     value_q;
    logic [31:0]             remaining_q;

    assign job_ready_o = state == IDLE;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Empty jobs are taken and skipped
                    if (job_valid_i && job_i.count != 32'd0) begin
                        state <= WRITE;
                    end
                end

                WRITE: begin
                    if (wb_ack_i) begin
                        state <= (remaining_q == 32'd1) ? IDLE : GAP;
                    end
                end

                GAP: begin
                    state <= WRITE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Job payload and word counter
    always_ff @(posedge clk) begin
        if (state == IDLE && job_valid_i) begin
            adr_q       <= job_i.base;
            value_q     <= job_i.value;
            remaining_q <= job_i.count;
        end else if (state == WRITE && wb_ack_i) begin
            adr_q       <= adr_q + 1'b1;
            remaining_q <= remaining_q - 1'b1;
        end
    end

    // Bus strobes drop in GAP so every word is its own cycle
    assign wb_cyc_o = state == WRITE;
    assign wb_stb_o = state == WRITE;
    assign wb_we_o  = state == WRITE;
    assign wb_sel_o = {2{wb_stb_o}};
    assign wb_adr_o = adr_q;
    assign wb_dat_o = value_q;

    property p_stb_in_cyc;
        @(posedge clk) disable iff (reset_i)
        wb_stb_o |-> wb_cyc_o;
    endproperty

    property p_bus_hold;
        @(posedge clk) disable iff (reset_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o);
    endproperty

    assert property (p_stb_in_cyc)
        else $error("wishbone stb without cyc");

    assert property (p_bus_hold)
        else $error("wishbone address or data moved before ack");

endmodule

// File: design/gpu_cmd_top.sv
/*
 * Command front end of the GPU. Chains decode, buffer management and
 * VRAM write stages and sets the framebuffer size for the whole tree.
 */

module gpu_cmd_top #(
    parameter int FB_WIDTH = 128,
    parameter int FB_HEIGHT = 128
    ) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,

    // Command stream
    input  wire logic                    cmd_tvalid_i,
    output      logic                    cmd_tready_o,
    input  wire logic [31:0]             cmd_tdata_i,

    // VRAM Wishbone master
    output      logic                    wb_cyc_o,
    output      logic                    wb_stb_o,
    output      logic                    wb_we_o,
    output      logic [1:0]              wb_sel_o,
    output      gpu_cmd_pkg::vram_addr_t wb_adr_o,
    output      gpu_cmd_pkg::pixel_t     wb_dat_o,
    input  wire logic                    wb_ack_i,

    // Display
    input  wire logic                    vsync_i,
    output      logic                    swap_o,
    output      gpu_cmd_pkg::vram_addr_t front_addr_o
    );

    logic                      dec_valid, dec_ready;
    gpu_cmd_pkg::decoded_cmd_t dec_cmd;
    logic                      job_valid, job_ready;
    gpu_cmd_pkg::write_job_t   job;

    cmd_decoder cmd_decoder_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_tvalid_i (cmd_tvalid_i),
        .cmd_tready_o (cmd_tready_o),
        .cmd_tdata_i  (cmd_tdata_i),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready),
        .dec_cmd_o    (dec_cmd)
    );

    buffer_manager #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) buffer_manager_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .dec_valid_i  (dec_valid),
        .dec_ready_o  (dec_ready),
        .dec_cmd_i    (dec_cmd),
        .job_valid_o  (job_valid),
        .job_ready_i  (job_ready),
        .job_o        (job),
        .vsync_i      (vsync_i),
        .swap_o       (swap_o),
        .front_addr_o (front_addr_o)
    );

    vram_writer vram_writer_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .job_valid_i (job_valid),
        .job_ready_o (job_ready),
        .job_i       (job),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_sel_o    (wb_sel_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_i    (wb_ack_i)
    );

endmodule

// File: tb/tb_vram_slave.sv
/*
 * Wishbone classic slave model for the VRAM port. Acks each word after a
 * random delay of 0 to 3 cycles and reports every completed write.
 */

module tb_vram_slave (
    input  wire logic                    clk,
    input  wire logic                    reset_i,

    // Wishbone classic slave side
    input  wire logic                    wb_cyc_i,
    input  wire logic                    wb_stb_i,
    input  wire logic                    wb_we_i,
    input  wire gpu_cmd_pkg::vram_addr_t wb_adr_i,
    input  wire gpu_cmd_pkg::pixel_t     wb_dat_i,
    output      logic                    wb_ack_o,

    // One entry per acked write
    output      logic                    wr_valid_o,
    output      gpu_cmd_pkg::vram_addr_t wr_adr_o,
    output      gpu_cmd_pkg::pixel_t     wr_dat_o,
    output      int                      write_count_o
    );

    integer     seed = 32'h565b_df22;
    integer     rnd;
    logic [1:0] delay_q;
    logic [1:0] wait_q;

    // Ack in the cycle where the wait count reaches the chosen delay
    assign wb_ack_o = wb_cyc_i && wb_stb_i && wait_q == delay_q;

    always @(posedge clk) begin
        if (reset_i) begin
            wait_q        <= 2'd0;
            delay_q       <= 2'd0;
            write_count_o <= 0;
        end else if (wb_ack_o) begin
            rnd = $random(seed);
            wait_q  <= 2'd0;
            delay_q <= rnd[1:0];
            if (wb_we_i) begin
                write_count_o <= write_count_o + 1;
            end
        end else if (wb_cyc_i && wb_stb_i) begin
            wait_q <= wait_q + 2'd1;
        end
    end

    assign wr_valid_o = wb_ack_o && wb_we_i;
    assign wr_adr_o   = wb_adr_i;
    assign wr_dat_o   = wb_dat_i;

endmodule

// File: tb/tb_gpu_cmd.sv
/*
 * Testbench for the GPU command front end. Sends clears, texture uploads
 * and swaps, predicts every VRAM write and swap, and checks them with
 * concurrent assertions against the Wishbone slave model.
 */

module tb_gpu_cmd;

    localparam int FB_WIDTH = 8;
    localparam int FB_HEIGHT = 4;
    localparam int N = FB_WIDTH * FB_HEIGHT;
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY = 10;
    localparam int EXP_DEPTH = 512;
    // Six full clears and eight texels
    localparam int TOTAL_WRITES = 6 * N + 8;
    // Up to 4 bus cycles per word plus the gap
    localparam int CYCLES_PER_WRITE = 5;
    localparam int MARGIN_CYCLES = 400;
    localparam int WATCHDOG_TIME = (TOTAL_WRITES * CYCLES_PER_WRITE + MARGIN_CYCLES) * CLK_PERIOD;

    logic                    clk, reset;
    logic                    cmd_tvalid, cmd_tready;
    logic [31:0]             cmd_tdata;
    logic                    wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0]              wb_sel;
    gpu_cmd_pkg::vram_addr_t wb_adr;
    gpu_cmd_pkg::pixel_t     wb_dat;
    logic                    vsync, swap;
    gpu_cmd_pkg::vram_addr_t front_addr;

    logic                    wr_valid;
    gpu_cmd_pkg::vram_addr_t wr_adr;
    gpu_cmd_pkg::pixel_t     wr_dat;
    int                      write_count;

    // Reference model of the pointers and the expected write stream
    gpu_cmd_pkg::vram_addr_t front_m, back_m, tex_m;
    gpu_cmd_pkg::vram_addr_t exp_adr_mem [0:EXP_DEPTH-1];
    gpu_cmd_pkg::pixel_t     exp_dat_mem [0:EXP_DEPTH-1];
    gpu_cmd_pkg::vram_addr_t exp_front_mem [0:15];
    gpu_cmd_pkg::vram_addr_t exp_adr, exp_front;
    gpu_cmd_pkg::pixel_t     exp_dat;
    int                      exp_total;
    int                      swaps_allowed, swaps_pushed, swaps_seen;
    int                      errors;

    gpu_cmd_top #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) gpu_cmd_top_inst (
        .clk          (clk),
        .reset_i      (reset),
        .cmd_tvalid_i (cmd_tvalid),
        .cmd_tready_o (cmd_tready),
        .cmd_tdata_i  (cmd_tdata),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_sel_o     (wb_sel),
        .wb_adr_o     (wb_adr),
        .wb_dat_o     (wb_dat),
        .wb_ack_i     (wb_ack),
        .vsync_i      (vsync),
        .swap_o       (swap),
        .front_addr_o (front_addr)
    );

    tb_vram_slave vram_slave_inst (
        .clk           (clk),
        .reset_i       (reset),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack_o      (wb_ack),
        .wr_valid_o    (wr_valid),
        .wr_adr_o      (wr_adr),
        .wr_dat_o      (wr_dat),
        .write_count_o (write_count)
    );

    assign exp_adr   = exp_adr_mem[write_count[8:0]];
    assign exp_dat   = exp_dat_mem[write_count[8:0]];
    assign exp_front = exp_front_mem[swaps_seen[3:0]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            swaps_seen <= 0;
        end else if (swap) begin
            swaps_seen <= swaps_seen + 1;
        end
    end

    a_wr_adr: assert property (@(posedge clk) disable iff (reset) wr_valid |-> wr_adr == exp_adr)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t wb_adr_o: got %h, expected %h", $time,
                     $sampled(wr_adr), $sampled(exp_adr));
        end

    a_wr_dat: assert property (@(posedge clk) disable iff (reset) wr_valid |-> wr_dat == exp_dat)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t wb_dat_o: got %h, expected %h", $time,
                     $sampled(wr_dat), $sampled(exp_dat));
        end

    a_wr_sel: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_sel == 2'b11)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t wb_sel_o: got %b, expected 11", $time, $sampled(wb_sel));
        end

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
                                 wr_valid |-> write_count < exp_total)
        else begin
            errors = errors + 1;
            $display("%0t: a VRAM write arrived that no command asked for", $time);
        end

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc && wb_we)
        else begin
            errors = errors + 1;
            $display("%0t: wishbone stb seen without cyc and we", $time);
        end

    a_bus_hold: assert property (@(posedge clk) disable iff (reset)
                                 wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat))
        else begin
            errors = errors + 1;
            $display("%0t: wishbone address or data changed while waiting for ack", $time);
        end

    a_swap_allowed: assert property (@(posedge clk) disable iff (reset)
                                     swap |-> swaps_seen < swaps_allowed)
        else begin
            errors = errors + 1;
            $display("%0t: swap_o pulsed when no swap was due", $time);
        end

    a_swap_front: assert property (@(posedge clk) disable iff (reset)
                                   swap |-> front_addr == exp_front)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t front_addr_o: got %h, expected %h", $time,
                     $sampled(front_addr), $sampled(exp_front));
        end

    a_front_hold: assert property (@(posedge clk) disable iff (reset) !$stable(front_addr) |-> swap)
        else begin
            errors = errors + 1;
            $display("%0t: front_addr_o changed without a swap pulse", $time);
        end

    a_swap_pulse: assert property (@(posedge clk) disable iff (reset) swap |=> !swap)
        else begin
            errors = errors + 1;
            $display("%0t: swap_o stayed high for more than one cycle", $time);
        end

    function automatic logic [31:0] cmd_word(input gpu_cmd_pkg::opcode_e op, input logic half,
                                             input logic wait_f, input gpu_cmd_pkg::pixel_t value);
        logic [31:0] word;
        word = '0;
        word[15:0] = value;
        word[gpu_cmd_pkg::OP_POS +: gpu_cmd_pkg::OP_SIZE] = op;
        word[gpu_cmd_pkg::HALF_SEL_BIT] = half;
        if (wait_f) begin
            word[gpu_cmd_pkg::WAIT_VSYNC_BIT] = 1'b1;
        end
        return word;
    endfunction

    // Every task starts and ends just after a rising edge
    task automatic send_word(input logic [31:0] word);
        cmd_tvalid = 1'b1;
        cmd_tdata  = word;
        while (!cmd_tready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        @(posedge clk);
        #DRIVE_DLY;
        cmd_tvalid = 1'b0;
    endtask

    task automatic expect_writes(input gpu_cmd_pkg::vram_addr_t base, input int count,
                                 input gpu_cmd_pkg::pixel_t value);
        int i;
        for (i = 0; i < count; i++) begin
            exp_adr_mem[exp_total] = base + i;
            exp_dat_mem[exp_total] = value;
            exp_total = exp_total + 1;
        end
    endtask

    task automatic clear_colour(input gpu_cmd_pkg::pixel_t value);
        expect_writes(back_m, N, value);
        send_word(cmd_word(gpu_cmd_pkg::OP_CLEAR, 1'b0, 1'b0, value));
    endtask

    task automatic clear_depth(input gpu_cmd_pkg::pixel_t value);
        expect_writes(2 * N, N, value);
        send_word(cmd_word(gpu_cmd_pkg::OP_CLEAR, 1'b1, 1'b0, value));
    endtask

    task automatic set_tex_addr(input gpu_cmd_pkg::vram_addr_t addr);
        tex_m = addr;
        send_word(cmd_word(gpu_cmd_pkg::OP_SET_TEX_ADDR, 1'b1, 1'b0, addr[31:16]));
        send_word(cmd_word(gpu_cmd_pkg::OP_SET_TEX_ADDR, 1'b0, 1'b0, addr[15:0]));
    endtask

    task automatic write_texel(input gpu_cmd_pkg::pixel_t value);
        expect_writes(tex_m, 1, value);
        tex_m = tex_m + 1;
        send_word(cmd_word(gpu_cmd_pkg::OP_WRITE_TEX, 1'b0, 1'b0, value));
    endtask

    task automatic swap_buffers(input logic wait_f);
        gpu_cmd_pkg::vram_addr_t tmp;
        tmp = front_m;
        front_m = back_m;
        back_m = tmp;
        exp_front_mem[swaps_pushed] = front_m;
        swaps_pushed = swaps_pushed + 1;
        if (!wait_f) begin
            swaps_allowed = swaps_allowed + 1;
        end
        send_word(cmd_word(gpu_cmd_pkg::OP_SWAP, 1'b0, wait_f, 16'h0000));
    endtask

    task automatic pulse_vsync();
        vsync = 1'b1;
        swaps_allowed = swaps_allowed + 1;
        @(posedge clk);
        #DRIVE_DLY;
        vsync = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_writes();
        while (write_count != exp_total) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic wait_swaps();
        while (swaps_seen != swaps_allowed) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        cmd_tvalid = 1'b0;
        cmd_tdata = '0;
        vsync = 1'b0;
        errors = 0;
        exp_total = 0;
        swaps_allowed = 0;
        swaps_pushed = 0;
        front_m = '0;
        back_m = N;
        tex_m = 3 * N;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        clear_colour(16'h1234);
        wait_writes();
        clear_depth(16'hffff);
        wait_writes();

        // Upper half set so the texture pointer leaves the 16-bit range
        set_tex_addr(32'h0001_0040);
        write_texel(16'h0a01);
        write_texel(16'h0a02);
        write_texel(16'h0a03);
        wait_writes();

        swap_buffers(1'b0);
        wait_swaps();
        clear_colour(16'h00f0);
        wait_writes();

        // Swap parked in stage 2 until vsync
        swap_buffers(1'b1);
        idle(20);
        pulse_vsync();
        wait_swaps();
        clear_colour(16'h0f0f);
        wait_writes();

        // Back to back commands with an unknown opcode in the middle
        write_texel(16'h5a01);
        write_texel(16'h5a02);
        send_word(32'h7f00_0000);
        write_texel(16'h5a03);
        write_texel(16'h5a04);
        clear_depth(16'h0001);
        swap_buffers(1'b0);
        clear_colour(16'hbeef);
        write_texel(16'h5a05);
        wait_writes();
        wait_swaps();
        idle(8);

        assert (write_count == exp_total && exp_total == TOTAL_WRITES)
            else begin
                errors = errors + 1;
                $display("Write total is wrong: %0d seen, %0d predicted", write_count, exp_total);
            end
        assert (swaps_seen == swaps_pushed)
            else begin
                errors = errors + 1;
                $display("Swap total is wrong: %0d seen, %0d sent", swaps_seen, swaps_pushed);
            end

        $display("Result: %0d errors, %0d of %0d writes, %0d swaps",
                 errors, write_count, exp_total, swaps_seen);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
design/gpu_cmd_pkg.sv
design/cmd_decoder.sv
design/buffer_manager.sv
design/vram_writer.sv
design/gpu_cmd_top.sv
tb/tb_vram_slave.sv
tb/tb_gpu_cmd.sv

// File: run.sh
#!/bin/sh
# Compile and run the GPU command front end testbench with Verilator.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_gpu_cmd
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
